/* source/mem_geometry_pkg.sv */
package mem_geometry_pkg;

   ////////////////////////////////////////////////////////////
   // Data word
   ////////////////////////////////////////////////////////////

   // ALU result and memory word share this width.
   localparam int unsigned DATA_WIDTH = 32;

   // Byte columns per word, each one separately writable.
   localparam int unsigned BYTE_LANES = 4;
   localparam int unsigned LANE_WIDTH = DATA_WIDTH / BYTE_LANES;

   ////////////////////////////////////////////////////////////
   // Addressing
   ////////////////////////////////////////////////////////////

   // Byte address seen by the stage.
   localparam int unsigned ADDR_WIDTH      = 10;
   // Byte address without the two offset bits.
   localparam int unsigned WORD_ADDR_WIDTH = 8;
   localparam int unsigned RAM_DEPTH       = 256;

   // Register file index carried to write-back.
   localparam int unsigned REG_INDEX_WIDTH = 5;

endpackage

/* source/mem_access_pkg.sv */
package mem_access_pkg;

   ////////////////////////////////////////////////////////////
   // Load/store size
   ////////////////////////////////////////////////////////////

   // Encoded like the low bits of the MIPS load opcodes.
   // Stores look only at the width.
   typedef enum logic [2:0] {
      SIZE_BYTE   = 3'b000,
      SIZE_HALF   = 3'b001,
      SIZE_WORD   = 3'b011,
      SIZE_BYTE_U = 3'b100,
      SIZE_HALF_U = 3'b101
   } mem_size_op_t;

   ////////////////////////////////////////////////////////////
   // Clear sweep
   ////////////////////////////////////////////////////////////

   typedef enum logic {
      CLEAR_RUN  = 1'b0,
      CLEAR_DONE = 1'b1
   } clear_state_t;

endpackage

/* source/store_lane_align.sv */
`timescale 1ns/1ns

module store_lane_align (
   input  mem_access_pkg::mem_size_op_t            i_size_op,
   input  logic [1:0]                              i_byte_offset,
   input  logic [mem_geometry_pkg::DATA_WIDTH-1:0] i_store_data,
   output logic [mem_geometry_pkg::DATA_WIDTH-1:0] o_lane_data,
   output logic [mem_geometry_pkg::BYTE_LANES-1:0] o_lane_enable
);

   logic is_byte;
   logic is_half;
   logic is_word;

   assign is_byte = (i_size_op == mem_access_pkg::SIZE_BYTE) ||
                    (i_size_op == mem_access_pkg::SIZE_BYTE_U);
   assign is_half = (i_size_op == mem_access_pkg::SIZE_HALF) ||
                    (i_size_op == mem_access_pkg::SIZE_HALF_U);
   assign is_word = !is_byte && !is_half;

   // Data is copied into every lane, so the enable alone picks the target.
   always_comb begin
      if (is_byte) begin
         o_lane_data   = {mem_geometry_pkg::BYTE_LANES{
                            i_store_data[mem_geometry_pkg::LANE_WIDTH-1:0]}};
         o_lane_enable = mem_geometry_pkg::BYTE_LANES'(1) << i_byte_offset;
      end
      else if (is_half) begin
         o_lane_data   = {(mem_geometry_pkg::BYTE_LANES / 2){
                            i_store_data[2*mem_geometry_pkg::LANE_WIDTH-1:0]}};
         // Lanes 0-1 or 2-3.
         o_lane_enable = mem_geometry_pkg::BYTE_LANES'(2'b11) << {i_byte_offset[1], 1'b0};
      end
      else begin
         o_lane_data   = i_store_data;
         o_lane_enable = '1;
      end
   end

   ////////////////////////////////////////////////////////////
   // Alignment check
   ////////////////////////////////////////////////////////////

   // Misaligned accesses are not supported by the stage.
   always_comb begin
      misaligned_access: assert final (!(is_half && i_byte_offset[0]) &&
                                       !(is_word && (i_byte_offset != 2'b00)))
         else $error("store_lane_align: misaligned access, op %s offset 0x%h",
                     i_size_op.name(), i_byte_offset);
   end

endmodule

/* source/load_extract.sv */
`timescale 1ns/1ns

module load_extract (
   input  logic [mem_geometry_pkg::DATA_WIDTH-1:0] i_read_data,
   input  mem_access_pkg::mem_size_op_t            i_size_op,
   input  logic [1:0]                              i_byte_offset,
   output logic [mem_geometry_pkg::DATA_WIDTH-1:0] o_load_data
);

   localparam int unsigned BYTE_FILL = mem_geometry_pkg::DATA_WIDTH -
                                       mem_geometry_pkg::LANE_WIDTH;
   localparam int unsigned HALF_FILL = mem_geometry_pkg::DATA_WIDTH -
                                       2 * mem_geometry_pkg::LANE_WIDTH;

   logic [mem_geometry_pkg::LANE_WIDTH-1:0]   sel_byte;
   logic [2*mem_geometry_pkg::LANE_WIDTH-1:0] sel_half;

   // Addressed byte and halfword.
   always_comb begin
      sel_byte = i_read_data[i_byte_offset * mem_geometry_pkg::LANE_WIDTH +:
                             mem_geometry_pkg::LANE_WIDTH];
      if (i_byte_offset[1]) begin
         sel_half = i_read_data[mem_geometry_pkg::DATA_WIDTH-1 -:
                                2*mem_geometry_pkg::LANE_WIDTH];
      end
      else begin
         sel_half = i_read_data[2*mem_geometry_pkg::LANE_WIDTH-1:0];
      end
   end

   // Extension by op.
   always_comb begin
      case (i_size_op)
         mem_access_pkg::SIZE_BYTE: begin
            o_load_data = {{BYTE_FILL{sel_byte[mem_geometry_pkg::LANE_WIDTH-1]}}, sel_byte};
         end
         mem_access_pkg::SIZE_BYTE_U: begin
            o_load_data = {{BYTE_FILL{1'b0}}, sel_byte};
         end
         mem_access_pkg::SIZE_HALF: begin
            o_load_data = {{HALF_FILL{sel_half[2*mem_geometry_pkg::LANE_WIDTH-1]}}, sel_half};
         end
         mem_access_pkg::SIZE_HALF_U: begin
            o_load_data = {{HALF_FILL{1'b0}}, sel_half};
         end
         default: begin
            // whole word, untouched
            o_load_data = i_read_data;
         end
      endcase
   end

endmodule

/* source/data_ram.sv */
`timescale 1ns/1ns

module data_ram (
   input  logic                                         i_clock,
   input  logic                                         i_soft_reset,
   input  logic                                         i_enable,
   input  logic [mem_geometry_pkg::WORD_ADDR_WIDTH-1:0] i_word_addr,
   input  logic [mem_geometry_pkg::BYTE_LANES-1:0]      i_lane_enable,
   input  logic [mem_geometry_pkg::DATA_WIDTH-1:0]      i_lane_data,
   output logic [mem_geometry_pkg::DATA_WIDTH-1:0]      o_read_data,
   output logic                                         o_soft_reset_ack
);

   localparam logic [mem_geometry_pkg::WORD_ADDR_WIDTH-1:0] LAST_WORD =
      mem_geometry_pkg::WORD_ADDR_WIDTH'(mem_geometry_pkg::RAM_DEPTH - 1);

   logic [mem_geometry_pkg::DATA_WIDTH-1:0]      mem [mem_geometry_pkg::RAM_DEPTH];
   mem_access_pkg::clear_state_t                 clear_state;
   logic [mem_geometry_pkg::WORD_ADDR_WIDTH-1:0] clear_addr;

   ////////////////////////////////////////////////////////////
   // Clear sweep
   ////////////////////////////////////////////////////////////

   // One word per cycle after reset is released.
   always_ff @(posedge i_clock) begin
      if (!i_soft_reset) begin
         clear_state <= mem_access_pkg::CLEAR_RUN;
         clear_addr  <= '0;
      end
      else if (clear_state == mem_access_pkg::CLEAR_RUN) begin
         clear_addr <= clear_addr + 1'b1;
         if (clear_addr == LAST_WORD) begin
            clear_state <= mem_access_pkg::CLEAR_DONE;
         end
      end
   end

   assign o_soft_reset_ack = (clear_state == mem_access_pkg::CLEAR_DONE);

   ////////////////////////////////////////////////////////////
   // Storage
   ////////////////////////////////////////////////////////////

   // The sweep owns the write port until it is done.
   always_ff @(posedge i_clock) begin
      if (i_soft_reset) begin
         if (clear_state == mem_access_pkg::CLEAR_RUN) begin
            mem[clear_addr] <= '0;
         end
         else if (i_enable) begin
            for (int lane = 0; lane < mem_geometry_pkg::BYTE_LANES; lane++) begin
               if (i_lane_enable[lane]) begin
                  mem[i_word_addr][lane*mem_geometry_pkg::LANE_WIDTH +:
                                   mem_geometry_pkg::LANE_WIDTH] <=
                     i_lane_data[lane*mem_geometry_pkg::LANE_WIDTH +:
                                 mem_geometry_pkg::LANE_WIDTH];
               end
            end
         end
      end
   end

   // Read-first, one cycle latency. Held while disabled.
   always_ff @(posedge i_clock) begin
      if (!i_soft_reset) begin
         o_read_data <= '0;
      end
      else if (i_enable) begin
         o_read_data <= mem[i_word_addr];
      end
   end

   // The top must hold writes off until the acknowledge.
   no_write_during_sweep: assert property (@(posedge i_clock) disable iff (!i_soft_reset)
      (clear_state == mem_access_pkg::CLEAR_RUN) |-> (i_lane_enable == '0))
      else $error("data_ram: lane enable 0x%h during clear sweep", i_lane_enable);

endmodule

/* source/dirty_word_tracker.sv */
`timescale 1ns/1ns

module dirty_word_tracker (
   input  logic                                         i_clock,
   input  logic                                         i_soft_reset,
   input  logic                                         i_write,
   input  logic [mem_geometry_pkg::WORD_ADDR_WIDTH-1:0] i_word_addr,
   input  logic [mem_geometry_pkg::WORD_ADDR_WIDTH-1:0] i_query_addr,
   output logic                                         o_dirty
);

   // One flag per memory word.
   logic [mem_geometry_pkg::RAM_DEPTH-1:0] dirty_flags;

   always_ff @(posedge i_clock) begin
      if (!i_soft_reset) begin
         dirty_flags <= '0;
      end
      else if (i_write) begin
         dirty_flags[i_word_addr] <= 1'b1;
      end
   end

   // Registered like the RAM read, so flag and word come out together.
   always_ff @(posedge i_clock) begin
      if (!i_soft_reset) begin
         o_dirty <= 1'b0;
      end
      else begin
         o_dirty <= dirty_flags[i_query_addr];
      end
   end

endmodule

/* source/mem_stage_top.sv */
`timescale 1ns/1ns

module mem_stage_top (
   input  logic                                         i_clock,
   input  logic                                         i_soft_reset,
   input  logic                                         i_enable_pipeline,
   input  logic                                         i_debug_mode,
   input  logic [mem_geometry_pkg::WORD_ADDR_WIDTH-1:0] i_debug_addr,
   input  logic [mem_geometry_pkg::DATA_WIDTH-1:0]      i_alu_result,
   input  logic [mem_geometry_pkg::DATA_WIDTH-1:0]      i_store_data,
   input  mem_access_pkg::mem_size_op_t                 i_size_op,
   input  logic                                         i_mem_read,
   input  logic                                         i_mem_write,
   input  logic                                         i_reg_write,
   input  logic                                         i_mem_to_reg,
   input  logic                                         i_halt_detected,
   input  logic [mem_geometry_pkg::REG_INDEX_WIDTH-1:0] i_dest_reg,
   output logic                                         o_reg_write,
   output logic                                         o_mem_to_reg,
   output logic                                         o_halt_detected,
   output logic [mem_geometry_pkg::REG_INDEX_WIDTH-1:0] o_dest_reg,
   output logic [mem_geometry_pkg::DATA_WIDTH-1:0]      o_alu_data,
   output logic [mem_geometry_pkg::DATA_WIDTH-1:0]      o_load_data,
   output logic [mem_geometry_pkg::DATA_WIDTH-1:0]      o_debug_data,
   output logic                                         o_debug_dirty,
   output logic                                         o_soft_reset_ack
);

   logic [mem_geometry_pkg::ADDR_WIDTH-1:0]      access_addr;
   logic [mem_geometry_pkg::WORD_ADDR_WIDTH-1:0] word_addr;
   logic [1:0]                                   byte_offset;
   logic [mem_geometry_pkg::DATA_WIDTH-1:0]      lane_data;
   logic [mem_geometry_pkg::BYTE_LANES-1:0]      lane_enable;
   logic [mem_geometry_pkg::BYTE_LANES-1:0]      gated_lane_enable;
   logic                                         write_allowed;
   logic                                         ram_enable;
   logic [mem_geometry_pkg::DATA_WIDTH-1:0]      ram_read_data;
   logic [mem_geometry_pkg::DATA_WIDTH-1:0]      extracted_load;

   // Stage 1, alongside the RAM read register.
   logic                                         s1_reg_write;
   logic                                         s1_mem_to_reg;
   logic                                         s1_halt_detected;
   logic [mem_geometry_pkg::REG_INDEX_WIDTH-1:0] s1_dest_reg;
   logic [mem_geometry_pkg::DATA_WIDTH-1:0]      s1_alu_data;
   mem_access_pkg::mem_size_op_t                 s1_size_op;
   logic [1:0]                                   s1_byte_offset;

   ////////////////////////////////////////////////////////////
   // Address and write control
   ////////////////////////////////////////////////////////////

   // Debug reads whole words, so its byte offset is zero.
   assign access_addr = i_debug_mode ? {i_debug_addr, 2'b00} :
                                       i_alu_result[mem_geometry_pkg::ADDR_WIDTH-1:0];
   assign word_addr   = access_addr[mem_geometry_pkg::ADDR_WIDTH-1:2];
   assign byte_offset = access_addr[1:0];

   assign write_allowed     = i_mem_write && !i_debug_mode && o_soft_reset_ack &&
                              i_enable_pipeline;
   assign gated_lane_enable = write_allowed ? lane_enable : '0;
   assign ram_enable        = i_enable_pipeline || i_debug_mode;

   store_lane_align u_store_lane_align (
      .i_size_op     (i_size_op),
      .i_byte_offset (byte_offset),
      .i_store_data  (i_store_data),
      .o_lane_data   (lane_data),
      .o_lane_enable (lane_enable)
   );

   data_ram u_data_ram (
      .i_clock          (i_clock),
      .i_soft_reset     (i_soft_reset),
      .i_enable         (ram_enable),
      .i_word_addr      (word_addr),
      .i_lane_enable    (gated_lane_enable),
      .i_lane_data      (lane_data),
      .o_read_data      (ram_read_data),
      .o_soft_reset_ack (o_soft_reset_ack)
   );

   dirty_word_tracker u_dirty_word_tracker (
      .i_clock      (i_clock),
      .i_soft_reset (i_soft_reset),
      .i_write      (|gated_lane_enable),
      .i_word_addr  (word_addr),
      .i_query_addr (word_addr),
      .o_dirty      (o_debug_dirty)
   );

   assign o_debug_data = ram_read_data;

   ////////////////////////////////////////////////////////////
   // Pipeline registers
   ////////////////////////////////////////////////////////////

   always_ff @(posedge i_clock) begin
      if (!i_soft_reset) begin
         s1_reg_write     <= 1'b0;
         s1_mem_to_reg    <= 1'b0;
         s1_halt_detected <= 1'b0;
         s1_dest_reg      <= '0;
         s1_alu_data      <= '0;
         s1_size_op       <= mem_access_pkg::SIZE_WORD;
         s1_byte_offset   <= '0;
      end
      else if (i_enable_pipeline) begin
         s1_reg_write     <= i_reg_write;
         s1_mem_to_reg    <= i_mem_to_reg;
         s1_halt_detected <= i_halt_detected;
         s1_dest_reg      <= i_dest_reg;
         s1_alu_data      <= i_alu_result;
         s1_size_op       <= i_size_op;
         s1_byte_offset   <= byte_offset;
      end
   end

   load_extract u_load_extract (
      .i_read_data   (ram_read_data),
      .i_size_op     (s1_size_op),
      .i_byte_offset (s1_byte_offset),
      .o_load_data   (extracted_load)
   );

   // Stage 2 feeds write-back.
   always_ff @(posedge i_clock) begin
      if (!i_soft_reset) begin
         o_reg_write     <= 1'b0;
         o_mem_to_reg    <= 1'b0;
         o_halt_detected <= 1'b0;
         o_dest_reg      <= '0;
         o_alu_data      <= '0;
         o_load_data     <= '0;
      end
      else if (i_enable_pipeline) begin
         o_reg_write     <= s1_reg_write;
         o_mem_to_reg    <= s1_mem_to_reg;
         o_halt_detected <= s1_halt_detected;
         o_dest_reg      <= s1_dest_reg;
         o_alu_data      <= s1_alu_data;
         o_load_data     <= extracted_load;
      end
   end

   ////////////////////////////////////////////////////////////
   // Checks
   ////////////////////////////////////////////////////////////

   read_write_exclusive: assert property (@(posedge i_clock) disable iff (!i_soft_reset)
      !(i_mem_read && i_mem_write))
      else $error("mem_stage_top: i_mem_read and i_mem_write both high");

endmodule

/* tests/mem_stage_checks.sv */
`timescale 1ns/1ns

module mem_stage_checks (
   input  logic                                         i_clock,
   input  logic                                         i_soft_reset,
   input  logic                                         i_enable_pipeline,
   input  logic                                         i_debug_mode,
   input  logic [mem_geometry_pkg::WORD_ADDR_WIDTH-1:0] i_debug_addr,
   input  logic [mem_geometry_pkg::DATA_WIDTH-1:0]      i_alu_result,
   input  logic [mem_geometry_pkg::DATA_WIDTH-1:0]      i_store_data,
   input  mem_access_pkg::mem_size_op_t                 i_size_op,
   input  logic                                         i_mem_write,
   input  logic                                         i_reg_write,
   input  logic                                         i_mem_to_reg,
   input  logic                                         i_halt_detected,
   input  logic [mem_geometry_pkg::REG_INDEX_WIDTH-1:0] i_dest_reg,
   input  logic [7:0]                                   i_wb_sideband,
   input  logic [mem_geometry_pkg::DATA_WIDTH-1:0]      i_wb_alu_data,
   input  logic [mem_geometry_pkg::DATA_WIDTH-1:0]      i_wb_load_data,
   input  logic [mem_geometry_pkg::DATA_WIDTH-1:0]      i_dbg_data,
   input  logic                                         i_dbg_dirty,
   input  logic                                         i_ack,
   output logic                                         o_failed
);

   logic [31:0]  shadow [mem_geometry_pkg::RAM_DEPTH];
   logic [255:0] dirty;
   int           sweep_count;
   logic         started;
   logic         ack_exp;
   logic [7:0]   word;
   logic [1:0]   off;
   logic         write_ok;
   logic [31:0]  exp_rd;
   logic         exp_dirty;
   logic         dbg_q;
   logic [7:0]   s1_side;
   logic [31:0]  s1_alu;
   mem_access_pkg::mem_size_op_t s1_op;
   logic [1:0]   s1_off;
   logic [7:0]   exp_side;
   logic [31:0]  exp_alu;
   logic [31:0]  exp_load;

   initial begin
      o_failed = 1'b0;
      started  = 1'b0;
   end

   // Store merges only the lanes of its width.
   function automatic logic [31:0] merge_store(input logic [31:0] old, input logic [31:0] data,
                                              input mem_access_pkg::mem_size_op_t op,
                                              input logic [1:0] ofs);
      logic [31:0] w;
      w = old;
      case (op)
         mem_access_pkg::SIZE_BYTE, mem_access_pkg::SIZE_BYTE_U: begin
            w[{ofs, 3'b000} +: 8] = data[7:0];
         end
         mem_access_pkg::SIZE_HALF, mem_access_pkg::SIZE_HALF_U: begin
            w[{ofs[1], 4'b0000} +: 16] = data[15:0];
         end
         default: w = data;
      endcase
      return w;
   endfunction

   function automatic logic [31:0] extend_load(input logic [31:0] w,
                                               input mem_access_pkg::mem_size_op_t op,
                                               input logic [1:0] ofs);
      logic [7:0]  b;
      logic [15:0] h;
      b = w[{ofs, 3'b000} +: 8];
      h = w[{ofs[1], 4'b0000} +: 16];
      case (op)
         mem_access_pkg::SIZE_BYTE:   return {{24{b[7]}}, b};
         mem_access_pkg::SIZE_BYTE_U: return {24'h0, b};
         mem_access_pkg::SIZE_HALF:   return {{16{h[15]}}, h};
         mem_access_pkg::SIZE_HALF_U: return {16'h0, h};
         default:                     return w;
      endcase
   endfunction

   assign word     = i_debug_mode ? i_debug_addr : i_alu_result[9:2];
   assign off      = i_debug_mode ? 2'b00 : i_alu_result[1:0];
   assign ack_exp  = (sweep_count == mem_geometry_pkg::RAM_DEPTH);
   assign write_ok = i_mem_write && !i_debug_mode && ack_exp && i_enable_pipeline;

   ////////////////////////////////////////////////////////////
   // Reference model
   ////////////////////////////////////////////////////////////

   always @(posedge i_clock) begin
      if (!i_soft_reset) begin
         started     <= 1'b1;
         sweep_count <= 0;
         for (int i = 0; i < mem_geometry_pkg::RAM_DEPTH; i++) begin
            shadow[i] <= '0;
         end
         dirty    <= '0;
         exp_rd   <= '0;
         exp_dirty <= 1'b0;
         dbg_q    <= 1'b0;
         s1_side  <= '0;
         s1_alu   <= '0;
         s1_op    <= mem_access_pkg::SIZE_WORD;
         s1_off   <= '0;
         exp_side <= '0;
         exp_alu  <= '0;
         exp_load <= '0;
      end
      else begin
         if (!ack_exp) begin
            sweep_count <= sweep_count + 1;
         end
         // Read-first, so a write on the same edge is not seen yet.
         if (i_enable_pipeline || i_debug_mode) begin
            exp_rd <= shadow[word];
         end
         exp_dirty <= dirty[word];
         dbg_q     <= i_debug_mode;
         if (write_ok) begin
            shadow[word] <= merge_store(shadow[word], i_store_data, i_size_op, off);
            dirty[word]  <= 1'b1;
         end
         if (i_enable_pipeline) begin
            s1_side  <= {i_reg_write, i_mem_to_reg, i_halt_detected, i_dest_reg};
            s1_alu   <= i_alu_result;
            s1_op    <= i_size_op;
            s1_off   <= off;
            exp_side <= s1_side;
            exp_alu  <= s1_alu;
            exp_load <= extend_load(exp_rd, s1_op, s1_off);
         end
      end
   end

   ////////////////////////////////////////////////////////////
   // Output checks
   ////////////////////////////////////////////////////////////

   ack_check: assert property (@(posedge i_clock) disable iff (!started) i_ack == ack_exp)
      else begin
         $display("[FAIL] o_soft_reset_ack expected 0x%h actual 0x%h",
                  $sampled(ack_exp), $sampled(i_ack));
         o_failed = 1'b1;
      end

   sideband_check: assert property (@(posedge i_clock) disable iff (!started)
      i_wb_sideband == exp_side)
      else begin
         $display("[FAIL] %s expected 0x%h actual 0x%h",
                  "{o_reg_write,o_mem_to_reg,o_halt_detected,o_dest_reg}",
                  $sampled(exp_side), $sampled(i_wb_sideband));
         o_failed = 1'b1;
      end

   alu_check: assert property (@(posedge i_clock) disable iff (!started) i_wb_alu_data == exp_alu)
      else begin
         $display("[FAIL] o_alu_data expected 0x%h actual 0x%h",
                  $sampled(exp_alu), $sampled(i_wb_alu_data));
         o_failed = 1'b1;
      end

   load_check: assert property (@(posedge i_clock) disable iff (!started)
      i_wb_load_data == exp_load)
      else begin
         $display("[FAIL] o_load_data expected 0x%h actual 0x%h",
                  $sampled(exp_load), $sampled(i_wb_load_data));
         o_failed = 1'b1;
      end

   // Debug outputs only mean something after a debug cycle.
   debug_data_check: assert property (@(posedge i_clock) disable iff (!started)
      dbg_q |-> (i_dbg_data == exp_rd))
      else begin
         $display("[FAIL] o_debug_data expected 0x%h actual 0x%h",
                  $sampled(exp_rd), $sampled(i_dbg_data));
         o_failed = 1'b1;
      end

   debug_dirty_check: assert property (@(posedge i_clock) disable iff (!started)
      dbg_q |-> (i_dbg_dirty == exp_dirty))
      else begin
         $display("[FAIL] o_debug_dirty expected 0x%h actual 0x%h",
                  $sampled(exp_dirty), $sampled(i_dbg_dirty));
         o_failed = 1'b1;
      end

endmodule

/* tests/mem_stage_tb.sv */
`timescale 1ns/1ns

module mem_stage_tb;

   localparam int unsigned CLOCK_PERIOD    = 8;
   localparam int unsigned WATCHDOG_CYCLES = mem_geometry_pkg::RAM_DEPTH + 600;

   logic                                 i_clock;
   logic                                 i_soft_reset;
   logic                                 i_enable_pipeline;
   logic                                 i_debug_mode;
   logic [7:0]                           i_debug_addr;
   logic [31:0]                          i_alu_result;
   logic [31:0]                          i_store_data;
   mem_access_pkg::mem_size_op_t         i_size_op;
   logic                                 i_mem_read;
   logic                                 i_mem_write;
   logic                                 i_reg_write;
   logic                                 i_mem_to_reg;
   logic                                 i_halt_detected;
   logic [4:0]                           i_dest_reg;
   logic                                 o_reg_write;
   logic                                 o_mem_to_reg;
   logic                                 o_halt_detected;
   logic [4:0]                           o_dest_reg;
   logic [31:0]                          o_alu_data;
   logic [31:0]                          o_load_data;
   logic [31:0]                          o_debug_data;
   logic                                 o_debug_dirty;
   logic                                 o_soft_reset_ack;
   logic                                 check_failed;
   int                                   seed;
   logic [9:0]                           written_addrs [$];
   mem_access_pkg::mem_size_op_t         ops [5];

   mem_stage_top DUT (.*);

   mem_stage_checks u_checks (
      .*,
      .i_wb_sideband  ({o_reg_write, o_mem_to_reg, o_halt_detected, o_dest_reg}),
      .i_wb_alu_data  (o_alu_data),
      .i_wb_load_data (o_load_data),
      .i_dbg_data     (o_debug_data),
      .i_dbg_dirty    (o_debug_dirty),
      .i_ack          (o_soft_reset_ack),
      .o_failed       (check_failed)
   );

   initial begin
      i_clock = 1'b0;
      forever #(CLOCK_PERIOD / 2) i_clock = ~i_clock;
   end

   initial begin
      #(WATCHDOG_CYCLES * CLOCK_PERIOD);
      $display("STATUS: FAIL");
      $fatal(1, "Watchdog expired before the test sequence finished.");
   end

   always @(posedge check_failed) begin
      $display("STATUS: FAIL");
      $fatal(1, "A check on the DUT outputs failed.");
   end

   ////////////////////////////////////////////////////////////
   // Stimulus tasks
   ////////////////////////////////////////////////////////////

   // Inputs change 1 ns after the rising edge.
   task automatic step();
      @(posedge i_clock);
      #1;
   endtask

   task automatic set_idle();
      i_mem_read      = 1'b0;
      i_mem_write     = 1'b0;
      i_debug_mode    = 1'b0;
      i_reg_write     = 1'b0;
      i_mem_to_reg    = 1'b0;
      i_halt_detected = 1'b0;
      i_size_op       = mem_access_pkg::SIZE_WORD;
      i_alu_result    = '0;
   endtask

   function automatic logic [9:0] rand_addr(input mem_access_pkg::mem_size_op_t op);
      logic [9:0] a;
      a = 10'($random(seed));
      if (op == mem_access_pkg::SIZE_WORD) begin
         a[1:0] = 2'b00;
      end
      else if (op == mem_access_pkg::SIZE_HALF || op == mem_access_pkg::SIZE_HALF_U) begin
         a[0] = 1'b0;
      end
      return a;
   endfunction

   task automatic store(input logic [9:0] addr, input mem_access_pkg::mem_size_op_t op,
                        input logic debug);
      set_idle();
      i_mem_write  = 1'b1;
      i_debug_mode = debug;
      i_debug_addr = addr[9:2];
      i_alu_result = {22'($random(seed)), addr};
      i_store_data = $random(seed);
      i_size_op    = op;
      if (!debug && i_enable_pipeline) begin
         written_addrs.push_back(addr);
      end
      step();
   endtask

   task automatic load(input logic [9:0] addr, input mem_access_pkg::mem_size_op_t op);
      set_idle();
      i_mem_read      = 1'b1;
      i_reg_write     = 1'b1;
      i_mem_to_reg    = 1'b1;
      i_halt_detected = 1'($random(seed));
      i_dest_reg      = 5'($random(seed));
      i_alu_result    = {22'($random(seed)), addr};
      i_size_op       = op;
      step();
   endtask

   task automatic debug_read(input logic [7:0] word);
      set_idle();
      i_debug_mode = 1'b1;
      i_debug_addr = word;
      step();
   endtask

   // Pipeline is held while the sweep runs.
   task automatic restart();
      set_idle();
      i_soft_reset      = 1'b0;
      i_enable_pipeline = 1'b0;
      repeat (3) step();
      i_soft_reset = 1'b1;
      do step(); while (!o_soft_reset_ack);
      i_enable_pipeline = 1'b1;
   endtask

   ////////////////////////////////////////////////////////////
   // Test sequence
   ////////////////////////////////////////////////////////////

   initial begin
      logic [9:0]                   a;
      logic [9:0]                   load_addr;
      mem_access_pkg::mem_size_op_t op;
      mem_access_pkg::mem_size_op_t lop;
      seed = 32'h465;
      ops  = '{mem_access_pkg::SIZE_BYTE, mem_access_pkg::SIZE_HALF, mem_access_pkg::SIZE_WORD,
               mem_access_pkg::SIZE_BYTE_U, mem_access_pkg::SIZE_HALF_U};
      i_soft_reset      = 1'b0;
      i_enable_pipeline = 1'b0;
      i_debug_addr      = '0;
      i_store_data      = '0;
      i_dest_reg        = '0;
      set_idle();
      restart();
      // Memory reads back zero and clean.
      repeat (16) debug_read(8'($random(seed)));
      // Word store followed by a word load.
      repeat (20) begin
         a = rand_addr(mem_access_pkg::SIZE_WORD);
         store(a, mem_access_pkg::SIZE_WORD, 1'b0);
         load(a, mem_access_pkg::SIZE_WORD);
      end
      // Partial stores and loads of every size.
      repeat (24) begin
         op        = ops[$unsigned($random(seed)) % 5];
         lop       = ops[$unsigned($random(seed)) % 5];
         a         = rand_addr(op);
         load_addr = rand_addr(lop);
         store(a, op, 1'b0);
         load({a[9:2], load_addr[1:0]}, lop);
      end
      // Stores during a stall must not land.
      a = rand_addr(mem_access_pkg::SIZE_WORD);
      store(a, mem_access_pkg::SIZE_WORD, 1'b0);
      i_enable_pipeline = 1'b0;
      repeat (3) store(a, mem_access_pkg::SIZE_WORD, 1'b0);
      i_enable_pipeline = 1'b1;
      load(a, mem_access_pkg::SIZE_WORD);
      // Stores in debug mode are blocked.
      repeat (4) begin
         a = rand_addr(mem_access_pkg::SIZE_WORD);
         store(a, mem_access_pkg::SIZE_WORD, 1'b1);
         debug_read(a[9:2]);
      end
      foreach (written_addrs[i]) debug_read(written_addrs[i][9:2]);
      // Second reset clears data and flags.
      restart();
      foreach (written_addrs[i]) debug_read(written_addrs[i][9:2]);
      set_idle();
      repeat (3) step();
      if (check_failed) begin
         $display("STATUS: FAIL");
         $fatal(1, "A check failed during the run.");
      end
      else begin
         $display("STATUS: PASS");
         $finish;
      end
   end

endmodule

/* sim.f */
source/mem_geometry_pkg.sv
source/mem_access_pkg.sv
source/store_lane_align.sv
source/load_extract.sv
source/data_ram.sv
source/dirty_word_tracker.sv
source/mem_stage_top.sv
tests/mem_stage_checks.sv
tests/mem_stage_tb.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -Wno-fatal
TOP       := mem_stage_tb
FILELIST  := sim.f
OBJ_DIR   := obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "STATUS: PASS"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
